// ==== buffer_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module buffer_ram (
  input  wire                               FPGA_CLK3,
  input  wire                               ram_en,       // port enable
  input  wire  [mz_bus_pkg::lane_n-1:0]     ram_we,       // per lane write
  input  wire  [mz_bus_pkg::ram_aw-1:0]     ram_addr,     // word address
  input  wire  mz_bus_pkg::data_t           wr_data,
  output mz_bus_pkg::data_t                 ram_rd_data   // valid one clk after en
);

  import mz_bus_pkg::*;

  data_t mem [ram_depth];  // 512 x 32, block ram

  // -----------------------------------------------
  // single port, read before write
  // -----------------------------------------------
  always_ff @(posedge FPGA_CLK3) begin
    if (ram_en) begin
      for (int i = 0; i < lane_n; i++) begin
        if (ram_we[i]) begin
          mem[ram_addr][i*lane_w +: lane_w] <= wr_data[i*lane_w +: lane_w];  // lane i
        end
      end
      ram_rd_data <= mem[ram_addr];  // old contents on a write
    end
  end

  // output holds its last value while ram_en is low,
  // the sum sequence relies on that for operand b

endmodule

`default_nettype wire

// ==== decoder_arg_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoder_arg_regs (
  input  wire                                FPGA_CLK3,
  input  wire                                SYS_RST_N,
  input  wire                                reg_wr_stb,   // one cycle write
  input  wire  [mz_bus_pkg::reg_off_w-1:0]   reg_off,      // byte offset
  input  wire  mz_bus_pkg::data_t            wr_data,
  output mz_bus_pkg::data_t                  reg_rd_data,  // combinational readback
  output logic                               dec_run       // decoder start level
);

  import mz_bus_pkg::*;

  data_t reg_run;     // control, bit 0 = run
  data_t reg_ncs;
  data_t reg_nct;
  data_t reg_n1;
  data_t reg_n2;
  data_t reg_nnobpa;
  data_t reg_nnobpb;
  data_t reg_pppa;
  data_t reg_pppb;
  data_t reg_lvl;

  // -----------------------------------------------
  // write decode, whole word per strobe
  // -----------------------------------------------
  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      reg_run    <= '0;
      reg_ncs    <= '0;
      reg_nct    <= '0;
      reg_n1     <= '0;
      reg_n2     <= '0;
      reg_nnobpa <= '0;
      reg_nnobpb <= '0;
      reg_pppa   <= '0;
      reg_pppb   <= '0;
      reg_lvl    <= '0;
    end else if (reg_wr_stb) begin
      case (reg_off)
        reg_off_run:    reg_run    <= wr_data;
        reg_off_ncs:    reg_ncs    <= wr_data;
        reg_off_nct:    reg_nct    <= wr_data;
        reg_off_n1:     reg_n1     <= wr_data;
        reg_off_n2:     reg_n2     <= wr_data;
        reg_off_nnobpa: reg_nnobpa <= wr_data;
        reg_off_nnobpb: reg_nnobpb <= wr_data;
        reg_off_pppa:   reg_pppa   <= wr_data;
        reg_off_pppb:   reg_pppb   <= wr_data;
        reg_off_lvl:    reg_lvl    <= wr_data;
        default:        ;                        // hole in the map, ignored
      endcase
    end
  end

  // -----------------------------------------------
  // readback mux
  // -----------------------------------------------
  always_comb begin
    case (reg_off)
      reg_off_run:    reg_rd_data = reg_run;
      reg_off_ncs:    reg_rd_data = reg_ncs;
      reg_off_nct:    reg_rd_data = reg_nct;
      reg_off_n1:     reg_rd_data = reg_n1;
      reg_off_n2:     reg_rd_data = reg_n2;
      reg_off_nnobpa: reg_rd_data = reg_nnobpa;
      reg_off_nnobpb: reg_rd_data = reg_nnobpb;
      reg_off_pppa:   reg_rd_data = reg_pppa;
      reg_off_pppb:   reg_rd_data = reg_pppb;
      reg_off_lvl:    reg_rd_data = reg_lvl;
      default:        reg_rd_data = '0;         // undefined offset reads zero
    endcase
  end

  assign dec_run = reg_run[0];  // start level out to the decoder

endmodule

`default_nettype wire

// ==== mz_bus_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module mz_bus_assertions (
  input  wire                       FPGA_CLK3,
  input  wire                       SYS_RST_N,
  input  wire                       mz_dtack,
  input  wire                       reg_wr_stb,
  input  wire                       as_detected,
  input  wire mz_bus_pkg::bus_state_t state
);

  import mz_bus_pkg::*;

  int fail_cnt = 0;  // read by the testbench top at the end

  // ------------------------------------------------
  // controller handshake properties
  // ------------------------------------------------
  idle_no_dtack : assert property (@(posedge FPGA_CLK3) disable iff (!SYS_RST_N)
    (state == st_idle) |-> !mz_dtack)
    else begin
      $error("dtack high while the controller is idle");
      fail_cnt = fail_cnt + 1;
    end

  wr_stb_single : assert property (@(posedge FPGA_CLK3) disable iff (!SYS_RST_N)
    reg_wr_stb |=> !reg_wr_stb)
    else begin
      $error("register write strobe longer than one cycle");
      fail_cnt = fail_cnt + 1;
    end

  dtack_release : assert property (@(posedge FPGA_CLK3) disable iff (!SYS_RST_N)
    (mz_dtack && !as_detected) |=> !mz_dtack)
    else begin
      $error("dtack still high one cycle after the strobe dropped");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind mz_bus_ctrl mz_bus_assertions u_asserts (
  .FPGA_CLK3   (FPGA_CLK3),
  .SYS_RST_N   (SYS_RST_N),
  .mz_dtack    (mz_dtack),
  .reg_wr_stb  (reg_wr_stb),
  .as_detected (as_detected),
  .state       (state)
);

`default_nettype wire

// ==== mz_bus_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module mz_bus_checker (
  input  wire                               FPGA_CLK3,
  input  wire                               SYS_RST_N,
  input  wire                               mz_as,
  input  wire                               mz_rw_raw,
  input  wire  [mz_bus_pkg::lane_n-1:0]     mz_byte_n,
  input  wire  [mz_bus_pkg::addr_w-1:0]     mz_addr,
  input  wire  mz_bus_pkg::data_t           mz_wr_data,
  input  wire                               mz_dtack,
  input  wire  mz_bus_pkg::data_t           mz_rd_data,
  input  wire                               mz_rd_drive,
  input  wire                               dec_run,
  input  wire  mz_bus_pkg::data_t           exp_rd,     // value from the stimulus table
  output int                                err_cnt,
  output int                                chk_cnt
);

  import mz_bus_pkg::*;

  data_t reg_m [256];        // register model, by byte offset
  data_t buf_m [ram_depth];  // buffer model
  logic  as_q0;              // strobe seen on the last edge
  logic  as_q1;
  logic  rst_q;
  logic  dtack_q;
  logic  busy;               // cycle detected, not yet released
  int    clk_cnt;
  int    det_cnt;            // edge count at detect

  initial begin
    err_cnt = 0;
    chk_cnt = 0;
    clk_cnt = 0;
    det_cnt = 0;
    busy    = 1'b0;
  end

  function automatic logic reg_defined(input logic [reg_off_w-1:0] off);
    return (off == 8'h00) || (off >= 8'h10 && off <= 8'h30 && off[1:0] == 2'b00);
  endfunction

  task automatic compare(input string name, input data_t got, input data_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ------------------------------------------------
  // one acknowledged cycle, model update and compare
  // ------------------------------------------------
  task automatic check_ack();
    logic [ram_aw-1:0]    w;
    logic [reg_off_w-1:0] off;
    logic                 is_buf;
    logic                 is_sum;
    data_t                expv;
    w      = mz_addr[ram_lsb +: ram_aw];
    off    = mz_addr[reg_off_w-1:0];
    is_buf = mz_addr[region_bit];
    is_sum = is_buf && mz_rw_raw && (w == sum_trigger_word);
    compare("dtack latency", 32'(clk_cnt - det_cnt - 1), is_sum ? 32'd8 : 32'd4);
    if (!mz_rw_raw) begin
      if (is_buf) begin
        for (int i = 0; i < lane_n; i++) begin
          if (!mz_byte_n[i]) begin
            buf_m[w][i*lane_w +: lane_w] = mz_wr_data[i*lane_w +: lane_w];  // low = lane on
          end
        end
      end else if (reg_defined(off)) begin
        reg_m[off] = mz_wr_data;  // whole word, lanes ignored
      end
    end else begin
      if (is_sum) begin
        expv = buf_m[sum_word_a] + buf_m[sum_word_b];  // wraps at 32 bits
      end else if (is_buf) begin
        expv = buf_m[w];
      end else begin
        expv = reg_defined(off) ? reg_m[off] : '0;
      end
      compare("mz_rd_data", mz_rd_data, expv);
      compare("mz_rd_data vs table", mz_rd_data, exp_rd);
    end
    compare("dec_run", 32'(dec_run), 32'(reg_m[reg_off_run][0]));
  endtask

  always @(posedge FPGA_CLK3) begin
    clk_cnt = clk_cnt + 1;
    if (!SYS_RST_N) begin
      for (int i = 0; i < 256; i++) begin
        reg_m[i] = '0;
      end
      busy = 1'b0;
    end else begin
      if (!rst_q) begin
        compare("mz_dtack", 32'(mz_dtack), 32'd0);  // first edge out of reset
        compare("dec_run", 32'(dec_run), 32'd0);
      end
      compare("mz_rd_drive", 32'(mz_rd_drive), 32'(mz_as && mz_rw_raw));  // read, strobe up
      if (!mz_as) begin
        busy = 1'b0;
      end
      if (as_q1 && as_q0 && mz_as && !busy) begin
        busy    = 1'b1;
        det_cnt = clk_cnt;
      end
      if (mz_dtack && !dtack_q) begin
        check_ack();  // dtack rose on the previous edge
      end
    end
    rst_q   = SYS_RST_N;
    as_q1   = as_q0;
    as_q0   = mz_as;
    dtack_q = mz_dtack;
  end

endmodule

`default_nettype wire

// ==== mz_bus_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module mz_bus_ctrl (
  input  wire                               FPGA_CLK3,
  input  wire                               SYS_RST_N,
  // host side
  input  wire                               mz_as,         // address strobe, high
  input  wire                               mz_rw,         // qualified r/w, 1 = read
  input  wire                               mz_rw_raw,     // raw r/w, 0 = write
  input  wire  [mz_bus_pkg::lane_n-1:0]     mz_byte_n,     // byte lanes, low active
  input  wire  [mz_bus_pkg::addr_w-1:0]     mz_addr,
  input  wire  mz_bus_pkg::data_t           mz_wr_data,
  output logic                              mz_dtack,
  output mz_bus_pkg::data_t                 mz_rd_data,
  output logic                              mz_rd_drive,   // data bus output enable
  // register block
  output logic                              reg_wr_stb,
  output logic [mz_bus_pkg::reg_off_w-1:0]  reg_off,
  input  wire  mz_bus_pkg::data_t           reg_rd_data,
  // buffer memory
  output logic                              ram_en,
  output logic [mz_bus_pkg::lane_n-1:0]     ram_we,
  output logic [mz_bus_pkg::ram_aw-1:0]     ram_addr,
  output mz_bus_pkg::data_t                 wr_data,
  input  wire  mz_bus_pkg::data_t           ram_rd_data
);

  import mz_bus_pkg::*;

  logic [1:0]        as_sync;        // strobe sync chain
  logic              as_detected;
  bus_state_t        state;
  logic [addr_w-1:0] latched_addr;
  logic [lane_n-1:0] latched_lanes;  // high = lane written
  logic              cyc_write;      // latched from raw r/w
  logic              cyc_buf;        // buffer region hit
  logic              cyc_sum;        // read of the trigger word
  logic              sum_phase;      // second cycle of st_sum
  logic [ram_aw-1:0] word_addr;
  data_t             operand_a;
  data_t             operand_b;

  // -----------------------------------------------
  // strobe synchronizer
  // -----------------------------------------------
  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      as_sync <= '0;
    end else begin
      as_sync <= {as_sync[0], mz_as};  // sample pin, then shift
    end
  end

  // two samples high and the pin still high, drops at once with the pin
  assign as_detected = as_sync[1] & as_sync[0] & mz_as;

  assign word_addr = latched_addr[ram_lsb +: ram_aw];
  assign cyc_buf   = latched_addr[region_bit];
  assign cyc_sum   = cyc_buf & ~cyc_write & (word_addr == sum_trigger_word);
  assign reg_off   = latched_addr[reg_off_w-1:0];

  assign mz_rd_drive = mz_rw & mz_as;  // drive only during a read strobe

  // -----------------------------------------------
  // bus state machine
  // -----------------------------------------------
  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      state      <= st_idle;
      mz_dtack   <= 1'b0;
      reg_wr_stb <= 1'b0;
      ram_en     <= 1'b0;
      ram_we     <= '0;
      sum_phase  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (as_detected) begin
            state <= st_latch;                    // addr and data latched below
          end
        end
        st_latch: begin
          if (as_detected) begin
            state      <= st_access;
            reg_wr_stb <= cyc_write & ~cyc_buf;   // register write, one cycle
            ram_en     <= cyc_buf;
            ram_we     <= (cyc_write & cyc_buf) ? latched_lanes : '0;
          end else begin
            state <= st_ack;                      // strobe lost, pulse dtack anyway
          end
        end
        st_access: begin
          state      <= st_capture;
          reg_wr_stb <= 1'b0;
          ram_en     <= 1'b0;
          ram_we     <= '0;
        end
        st_capture: begin
          if (cyc_sum) begin
            state  <= st_fetch_a;
            ram_en <= 1'b1;                       // read word a next edge
          end else begin
            state <= st_ack;
          end
        end
        st_fetch_a: begin
          state <= st_fetch_b;                    // word b read next edge
        end
        st_fetch_b: begin
          state  <= st_sum;
          ram_en <= 1'b0;
        end
        st_sum: begin
          sum_phase <= ~sum_phase;
          if (sum_phase) begin
            state <= st_ack;                      // add done
          end
        end
        st_ack: begin
          mz_dtack <= 1'b1;
          state    <= st_release;
        end
        st_release: begin
          if (!as_detected) begin
            mz_dtack <= 1'b0;                     // host dropped the strobe
            state    <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // -----------------------------------------------
  // address, data and sum datapath
  // -----------------------------------------------
  always_ff @(posedge FPGA_CLK3) begin
    case (state)
      st_idle: begin
        if (as_detected) begin
          latched_addr  <= mz_addr;
          wr_data       <= mz_wr_data;            // host holds it until dtack
          latched_lanes <= ~mz_byte_n;
          cyc_write     <= ~mz_rw_raw;
        end
      end
      st_latch: begin
        ram_addr <= word_addr;
      end
      st_capture: begin
        mz_rd_data <= cyc_buf ? ram_rd_data : reg_rd_data;
        ram_addr   <= sum_word_a;                 // only used on a sum read
      end
      st_fetch_a: begin
        ram_addr <= sum_word_b;
      end
      st_fetch_b: begin
        operand_a <= ram_rd_data;                 // word a out of the ram
      end
      st_sum: begin
        if (!sum_phase) begin
          operand_b <= ram_rd_data;               // word b, ram output held
        end else begin
          mz_rd_data <= operand_a + operand_b;    // wraps mod 2^32
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== mz_bus_pkg.sv ====
`default_nettype none

package mz_bus_pkg;

  // -----------------------------------------------
  // bus geometry
  // -----------------------------------------------
  localparam int addr_w    = 24;               // host address bus
  localparam int data_w    = 32;               // host data bus
  localparam int lane_n    = 4;                // byte lanes per word
  localparam int lane_w    = data_w / lane_n;  // bits per lane
  localparam int ram_aw    = 9;                // buffer word address
  localparam int ram_depth = 1 << ram_aw;      // 512 words
  localparam int ram_lsb   = 2;                // byte addr -> word addr
  localparam int reg_off_w = 8;                // register offset, addr 7:0

  // address bit 13 splits the map, set = buffer
  localparam int region_bit = 13;

  // -----------------------------------------------
  // decoder register map, byte offsets
  // -----------------------------------------------
  localparam logic [reg_off_w-1:0] reg_off_run    = 8'h00;  // bit 0 = start
  localparam logic [reg_off_w-1:0] reg_off_ncs    = 8'h10;  // coding scheme
  localparam logic [reg_off_w-1:0] reg_off_nct    = 8'h14;  // channel type
  localparam logic [reg_off_w-1:0] reg_off_n1     = 8'h18;
  localparam logic [reg_off_w-1:0] reg_off_n2     = 8'h1c;
  localparam logic [reg_off_w-1:0] reg_off_nnobpa = 8'h20;  // out bits part a
  localparam logic [reg_off_w-1:0] reg_off_nnobpb = 8'h24;  // out bits part b
  localparam logic [reg_off_w-1:0] reg_off_pppa   = 8'h28;  // puncture part a
  localparam logic [reg_off_w-1:0] reg_off_pppb   = 8'h2c;  // puncture part b
  localparam logic [reg_off_w-1:0] reg_off_lvl    = 8'h30;  // level

  // reading word 0 returns word 1 + word 2
  localparam logic [ram_aw-1:0] sum_trigger_word = 9'd0;
  localparam logic [ram_aw-1:0] sum_word_a       = 9'd1;
  localparam logic [ram_aw-1:0] sum_word_b       = 9'd2;

  typedef logic [data_w-1:0] data_t;

  // bus controller states
  typedef enum logic [3:0] {
    st_idle,     // wait for strobe
    st_latch,    // address held, decide
    st_access,   // strobe to regs or ram
    st_capture,  // grab read result
    st_fetch_a,  // sum operand a read
    st_fetch_b,  // sum operand b read
    st_sum,      // add, two cycles
    st_ack,      // raise dtack
    st_release   // hold dtack until strobe drops
  } bus_state_t;

endpackage

`default_nettype wire

// ==== mz_bus_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mz_bus_tb;

  import mz_bus_pkg::*;

  logic              FPGA_CLK3;
  logic              SYS_RST_N;
  logic              mz_as;
  logic              mz_rw;
  logic              mz_rw_raw;
  logic [lane_n-1:0] mz_byte_n;
  logic [addr_w-1:0] mz_addr;
  data_t             mz_wr_data;
  logic              mz_dtack;
  data_t             mz_rd_data;
  logic              mz_rd_drive;
  logic              dec_run;
  data_t             exp_rd;        // current table expectation
  int                err_cnt;
  int                chk_cnt;
  logic              timed_out;

  // ------------------------------------------------
  // stimulus table
  // ------------------------------------------------
  logic              tab_wr    [72];
  logic [addr_w-1:0] tab_addr  [72];
  logic [lane_n-1:0] tab_lanes [72];  // high = lane written
  data_t             tab_data  [72];
  data_t             tab_exp   [72];  // expected read value
  int                n_ent;
  data_t             lcg_state;
  data_t             buf_sh    [ram_depth];  // expected buffer contents
  data_t             reg_sh    [10];
  logic [7:0]        reg_offs  [10] = '{8'h00, 8'h10, 8'h14, 8'h18, 8'h1c,
                                        8'h20, 8'h24, 8'h28, 8'h2c, 8'h30};

  mz_bus_top dut (
    .FPGA_CLK3 (FPGA_CLK3), .SYS_RST_N (SYS_RST_N), .mz_as (mz_as), .mz_rw (mz_rw),
    .mz_rw_raw (mz_rw_raw), .mz_byte_n (mz_byte_n), .mz_addr (mz_addr),
    .mz_wr_data (mz_wr_data), .mz_dtack (mz_dtack), .mz_rd_data (mz_rd_data),
    .mz_rd_drive (mz_rd_drive), .dec_run (dec_run)
  );

  mz_bus_checker u_check (
    .FPGA_CLK3 (FPGA_CLK3), .SYS_RST_N (SYS_RST_N), .mz_as (mz_as),
    .mz_rw_raw (mz_rw_raw), .mz_byte_n (mz_byte_n), .mz_addr (mz_addr),
    .mz_wr_data (mz_wr_data), .mz_dtack (mz_dtack), .mz_rd_data (mz_rd_data),
    .mz_rd_drive (mz_rd_drive), .dec_run (dec_run), .exp_rd (exp_rd),
    .err_cnt (err_cnt), .chk_cnt (chk_cnt)
  );

  initial begin
    FPGA_CLK3 = 1'b0;
    forever #2 FPGA_CLK3 = ~FPGA_CLK3;  // 4 ns period
  end

  function automatic data_t lcg_next(input data_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [addr_w-1:0] reg_addr(input logic [7:0] off);
    return {16'h0000, off};  // bit 13 clear
  endfunction

  function automatic logic [addr_w-1:0] buf_addr(input int w);
    return (24'd1 << region_bit) | {13'd0, w[8:0], 2'b00};
  endfunction

  task automatic add_entry(input logic wr, input logic [addr_w-1:0] a,
                           input logic [lane_n-1:0] l, input data_t d, input data_t e);
    tab_wr[n_ent]    = wr;
    tab_addr[n_ent]  = a;
    tab_lanes[n_ent] = l;
    tab_data[n_ent]  = d;
    tab_exp[n_ent]   = e;
    n_ent++;
  endtask

  task automatic add_buf_write(input int w, input logic [lane_n-1:0] l, input data_t d);
    for (int i = 0; i < lane_n; i++) begin
      if (l[i]) begin
        buf_sh[w][i*lane_w +: lane_w] = d[i*lane_w +: lane_w];
      end
    end
    add_entry(1'b1, buf_addr(w), l, d, '0);
  endtask

  task automatic add_buf_read(input int w);
    add_entry(1'b0, buf_addr(w), '0, '0,
              (w == 0) ? buf_sh[1] + buf_sh[2] : buf_sh[w]);  // word 0 reads the sum
  endtask

  task automatic build_table();
    n_ent     = 0;
    lcg_state = 32'h2fb9a1ea;
    for (int k = 0; k < 10; k++) begin
      add_entry(1'b0, reg_addr(reg_offs[k]), '0, '0, '0);  // all clear after reset
    end
    add_entry(1'b0, reg_addr(8'h04), '0, '0, '0);
    for (int k = 0; k < 10; k++) begin
      lcg_state = lcg_next(lcg_state);
      reg_sh[k] = (k == 0) ? (lcg_state | 32'd1) : lcg_state;  // run bit set
      add_entry(1'b1, reg_addr(reg_offs[k]), 4'hf, reg_sh[k], '0);
    end
    for (int k = 0; k < 10; k++) begin
      add_entry(1'b0, reg_addr(reg_offs[k]), '0, '0, reg_sh[k]);
    end
    add_entry(1'b1, reg_addr(8'h00), 4'hf, 32'ha5a5_0000, '0);  // drop dec_run
    add_entry(1'b0, reg_addr(8'h00), '0, '0, 32'ha5a5_0000);
    add_entry(1'b1, reg_addr(8'h08), 4'hf, 32'hdead_beef, '0);  // hole in the map
    add_entry(1'b0, reg_addr(8'h08), '0, '0, '0);
    add_entry(1'b0, reg_addr(8'h34), '0, '0, '0);
    for (int w = 0; w < 8; w++) begin
      lcg_state = lcg_next(lcg_state);
      add_buf_write(w, 4'hf, lcg_state);
    end
    lcg_state = lcg_next(lcg_state);
    add_buf_write(511, 4'hf, lcg_state);  // top word
    add_buf_write(3, 4'b0101, 32'h1122_3344);
    add_buf_write(4, 4'b1000, 32'h5566_7788);
    add_buf_write(5, 4'b0011, 32'h99aa_bbcc);
    for (int w = 1; w < 8; w++) begin
      add_buf_read(w);
    end
    add_buf_read(511);
    add_buf_read(0);
    add_buf_write(1, 4'hf, 32'hffff_fff0);  // sum past 2^32
    add_buf_write(2, 4'hf, 32'h0000_0025);
    add_buf_read(0);
    add_buf_read(1);
    add_buf_read(2);
  endtask

  // ------------------------------------------------
  // one host bus cycle
  // ------------------------------------------------
  task automatic run_cycle(input int i);
    int t;
    @(negedge FPGA_CLK3);
    mz_addr    = tab_addr[i];
    mz_wr_data = tab_wr[i] ? tab_data[i] : '0;
    mz_byte_n  = ~tab_lanes[i];
    mz_rw      = ~tab_wr[i];
    mz_rw_raw  = ~tab_wr[i];
    exp_rd     = tab_exp[i];
    mz_as      = 1'b1;
    t = 0;
    while (mz_dtack !== 1'b1 && t < 40) begin
      @(negedge FPGA_CLK3);
      t++;
    end
    if (mz_dtack !== 1'b1) begin
      $display("timeout: no dtack for table entry %0d", i);
      timed_out = 1'b1;
    end
    mz_as = 1'b0;  // host lets go after dtack
    t = 0;
    while (mz_dtack !== 1'b0 && t < 40) begin
      @(negedge FPGA_CLK3);
      t++;
    end
    if (mz_dtack !== 1'b0) begin
      $display("timeout: dtack stuck high after table entry %0d", i);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    SYS_RST_N  = 1'b0;
    mz_as      = 1'b0;
    mz_rw      = 1'b1;
    mz_rw_raw  = 1'b1;
    mz_byte_n  = '1;
    mz_addr    = '0;
    mz_wr_data = '0;
    exp_rd     = '0;
    timed_out  = 1'b0;
    build_table();
    repeat (8) @(negedge FPGA_CLK3);
    SYS_RST_N = 1'b1;
    repeat (2) @(negedge FPGA_CLK3);
    for (int i = 0; i < n_ent && !timed_out; i++) begin
      run_cycle(i);
    end
    repeat (4) @(negedge FPGA_CLK3);
    $display("summary: %0d checks, %0d errors, %0d assertion failures, timeout %0d",
             chk_cnt, err_cnt, dut.u_ctrl.u_asserts.fail_cnt, timed_out);
    if (err_cnt == 0 && dut.u_ctrl.u_asserts.fail_cnt == 0 && !timed_out && chk_cnt > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mz_bus_top.f ====
mz_bus_pkg.sv
decoder_arg_regs.sv
buffer_ram.sv
mz_bus_ctrl.sv
mz_bus_top.sv
mz_bus_assertions.sv
mz_bus_checker.sv
mz_bus_tb.sv

// ==== mz_bus_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mz_bus_top (
  input  wire                               FPGA_CLK3,
  input  wire                               SYS_RST_N,
  input  wire                               mz_as,
  input  wire                               mz_rw,
  input  wire                               mz_rw_raw,
  input  wire  [mz_bus_pkg::lane_n-1:0]     mz_byte_n,
  input  wire  [mz_bus_pkg::addr_w-1:0]     mz_addr,
  input  wire  mz_bus_pkg::data_t           mz_wr_data,
  output logic                              mz_dtack,
  output mz_bus_pkg::data_t                 mz_rd_data,
  output logic                              mz_rd_drive,
  output logic                              dec_run      // start level for the decoder
);

  import mz_bus_pkg::*;

  logic                 reg_wr_stb;
  logic [reg_off_w-1:0] reg_off;
  data_t                reg_rd_data;
  logic                 ram_en;
  logic [lane_n-1:0]    ram_we;
  logic [ram_aw-1:0]    ram_addr;
  data_t                ram_rd_data;
  data_t                wr_data;      // shared by regs and ram

  // -----------------------------------------------
  // bus controller
  // -----------------------------------------------
  mz_bus_ctrl u_ctrl (
    .FPGA_CLK3   (FPGA_CLK3),
    .SYS_RST_N   (SYS_RST_N),
    .mz_as       (mz_as),
    .mz_rw       (mz_rw),
    .mz_rw_raw   (mz_rw_raw),
    .mz_byte_n   (mz_byte_n),
    .mz_addr     (mz_addr),
    .mz_wr_data  (mz_wr_data),
    .mz_dtack    (mz_dtack),
    .mz_rd_data  (mz_rd_data),
    .mz_rd_drive (mz_rd_drive),
    .reg_wr_stb  (reg_wr_stb),
    .reg_off     (reg_off),
    .reg_rd_data (reg_rd_data),
    .ram_en      (ram_en),
    .ram_we      (ram_we),
    .ram_addr    (ram_addr),
    .wr_data     (wr_data),
    .ram_rd_data (ram_rd_data)
  );

  decoder_arg_regs u_regs (
    .FPGA_CLK3   (FPGA_CLK3),
    .SYS_RST_N   (SYS_RST_N),
    .reg_wr_stb  (reg_wr_stb),
    .reg_off     (reg_off),
    .wr_data     (wr_data),
    .reg_rd_data (reg_rd_data),
    .dec_run     (dec_run)
  );

  buffer_ram u_ram (
    .FPGA_CLK3   (FPGA_CLK3),
    .ram_en      (ram_en),
    .ram_we      (ram_we),
    .ram_addr    (ram_addr),
    .wr_data     (wr_data),
    .ram_rd_data (ram_rd_data)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the mz_bus testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module mz_bus_tb -f mz_bus_top.f -o mz_bus_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/mz_bus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
